// ==== common/ts_replacer_macros.svh ====
`ifndef TS_REPLACER_MACROS_SVH
`define TS_REPLACER_MACROS_SVH

// host register word
`define TS_DATA_WIDTH 32

// transport packet geometry
`define TS_PACKET_BYTES 188
`define TS_PACKET_WORDS 47
`define TS_SYNC_BYTE 8'h47

// pid table and replacement memory sizes
`define TS_PID_SLOTS 4
`define TS_DATA_GROUPS 2
`define TS_RAM_WORDS (`TS_PACKET_WORDS * `TS_DATA_GROUPS)

`endif

// ==== common/ts_replacer_pkg.sv ====
`include "ts_replacer_macros.svh"

package ts_replacer_pkg;

	typedef logic [12:0] pid_t;

	// field view of one pid table slot as the host writes it
	typedef struct packed {
		logic [14:0] pad_hi;
		logic        enable;
		logic [2:0]  pad_lo;
		pid_t        pid;
	} pid_fields_t;

	// same host word, raw for transfer and decoded for the table
	typedef union packed {
		logic [`TS_DATA_WIDTH-1:0] raw;
		pid_fields_t               fields;
	} pid_cfg_u;

	// position within a packet
	typedef logic [$clog2(`TS_PACKET_BYTES)-1:0] byte_index_t;

	// which stored replacement packet is in use
	typedef logic [$clog2(`TS_DATA_GROUPS)-1:0] group_index_t;

	typedef logic [$clog2(`TS_RAM_WORDS)-1:0] ram_addr_t;

endpackage

// ==== design/pid_filter_table.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module pid_filter_table (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      update_pid_request,
	input  logic [`TS_DATA_WIDTH-1:0] pid_index,
	input  ts_replacer_pkg::pid_cfg_u pid,
	output ts_replacer_pkg::pid_cfg_u out_pid,
	input  ts_replacer_pkg::pid_t     pid_candidate,
	output logic                      pid_hit
);
	import ts_replacer_pkg::*;

	pid_t                             slot_pid [`TS_PID_SLOTS];
	logic                             slot_enable [`TS_PID_SLOTS];
	logic [$clog2(`TS_PID_SLOTS)-1:0] slot_sel;
	logic                             index_valid;

	assign index_valid = (pid_index < `TS_PID_SLOTS);
	assign slot_sel = pid_index[$clog2(`TS_PID_SLOTS)-1:0];

	// host write, out of range indexes are dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TS_PID_SLOTS; i++) begin
				slot_pid[i] <= '0;
				slot_enable[i] <= 1'b0;
			end
		end else if (update_pid_request && index_valid) begin
			slot_pid[slot_sel] <= pid.fields.pid;
			slot_enable[slot_sel] <= pid.fields.enable;
		end
	end

	// readback with padding forced to zero
	always_comb begin
		out_pid.raw = '0;
		if (index_valid) begin
			out_pid.fields.enable = slot_enable[slot_sel];
			out_pid.fields.pid = slot_pid[slot_sel];
		end
	end

	// all slots compared at once
	always_comb begin
		pid_hit = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (slot_enable[i] && (slot_pid[i] == pid_candidate)) begin
				pid_hit = 1'b1;
			end
		end
	end

endmodule

// ==== design/readback_pump.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module readback_pump (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       pump_data_request,
	output logic                       pump_data_request_ready,
	output ts_replacer_pkg::ram_addr_t word_addr,
	input  logic [`TS_DATA_WIDTH-1:0]  word_data,
	output logic [`TS_DATA_WIDTH-1:0]  out_data,
	output logic [`TS_DATA_WIDTH-1:0]  out_data_index
);
	import ts_replacer_pkg::*;

	localparam logic PUMP_IDLE = 1'b0;
	localparam logic PUMP_BUSY = 1'b1;

	logic                                 state;
	// one extra count marks the end of the sweep
	logic [$clog2(`TS_RAM_WORDS + 1)-1:0] word_count;

	assign word_addr = ram_addr_t'(word_count);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= PUMP_IDLE;
			word_count <= '0;
			pump_data_request_ready <= 1'b0;
			out_data <= '0;
			out_data_index <= '0;
		end else begin
			case (state)
				PUMP_IDLE: begin
					if (pump_data_request) begin
						pump_data_request_ready <= 1'b0;
						word_count <= '0;
						state <= PUMP_BUSY;
					end
				end
				PUMP_BUSY: begin
					if (word_count < `TS_RAM_WORDS) begin
						out_data <= word_data;
						out_data_index <= `TS_DATA_WIDTH'(word_count);
						word_count <= word_count + 1'b1;
					end else begin
						// whole memory shown, hand back to host
						pump_data_request_ready <= 1'b1;
						state <= PUMP_IDLE;
					end
				end
				default: state <= PUMP_IDLE;
			endcase
		end
	end

endmodule

// ==== design/replace_data_ram.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module replace_data_ram (
	input  logic                          clk,
	input  logic                          update_data_request,
	input  logic [`TS_DATA_WIDTH-1:0]     in_data_index,
	input  logic [`TS_DATA_WIDTH-1:0]     in_data,
	input  ts_replacer_pkg::ram_addr_t    word_addr,
	output logic [`TS_DATA_WIDTH-1:0]     word_data,
	input  ts_replacer_pkg::group_index_t byte_group,
	input  ts_replacer_pkg::byte_index_t  byte_index,
	output logic [7:0]                    byte_data
);
	import ts_replacer_pkg::*;

	// byte address over all groups, four byte lanes per word
	localparam int BYTE_ADDR_W = $clog2(`TS_RAM_WORDS * 4);

	logic [`TS_DATA_WIDTH-1:0] mem [`TS_RAM_WORDS];
	logic [BYTE_ADDR_W-1:0]    byte_addr;
	ram_addr_t                 byte_word;
	logic [1:0]                byte_lane;

	always_ff @(posedge clk) begin
		if (update_data_request && (in_data_index < `TS_RAM_WORDS)) begin
			mem[ram_addr_t'(in_data_index)] <= in_data;
		end
	end

	// host side word read
	assign word_data = mem[word_addr];

	// stream side byte read, lane 0 sits in the low byte
	assign byte_addr = BYTE_ADDR_W'(byte_group) * BYTE_ADDR_W'(`TS_PACKET_BYTES)
		+ BYTE_ADDR_W'(byte_index);
	assign byte_word = ram_addr_t'(byte_addr >> 2);
	assign byte_lane = byte_addr[1:0];
	assign byte_data = mem[byte_word][8 * byte_lane +: 8];

endmodule

// ==== design/ts_replacer.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module ts_replacer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      update_pid_request,
	input  logic [`TS_DATA_WIDTH-1:0] pid_index,
	input  ts_replacer_pkg::pid_cfg_u pid,
	output ts_replacer_pkg::pid_cfg_u out_pid,
	input  logic                      update_data_request,
	input  logic [`TS_DATA_WIDTH-1:0] in_data_index,
	input  logic [`TS_DATA_WIDTH-1:0] in_data,
	input  logic                      pump_data_request,
	output logic                      pump_data_request_ready,
	output logic [`TS_DATA_WIDTH-1:0] out_data,
	output logic [`TS_DATA_WIDTH-1:0] out_data_index,
	input  logic                      match_enable,
	input  logic                      pass_all,
	output logic [`TS_DATA_WIDTH-1:0] matched_count,
	input  logic [7:0]                mpeg_data,
	input  logic                      mpeg_valid,
	input  logic                      mpeg_sync,
	output logic [7:0]                ts_out,
	output logic                      ts_out_valid,
	output logic                      ts_out_sync
);
	import ts_replacer_pkg::*;

	logic [7:0]                stage1_data;
	logic [7:0]                stage2_data;
	logic [7:0]                stage3_data;
	logic                      stage2_sync;
	logic                      stage3_sync;
	logic                      pid_hit;
	logic                      emit;
	logic                      restart;
	logic                      forwarding;
	logic                      packet_last;
	byte_index_t               byte_index;
	group_index_t              group_index;
	logic [7:0]                ram_byte;
	ram_addr_t                 pump_addr;
	logic [`TS_DATA_WIDTH-1:0] pump_word;

	// candidate pid is stage 1 low bits joined with the byte arriving now
	pid_filter_table u_pid_filter_table (
		.clk(clk), .rst_n(rst_n), .update_pid_request(update_pid_request),
		.pid_index(pid_index), .pid(pid), .out_pid(out_pid),
		.pid_candidate({stage1_data[4:0], mpeg_data}), .pid_hit(pid_hit)
	);

	replace_data_ram u_replace_data_ram (
		.clk(clk), .update_data_request(update_data_request),
		.in_data_index(in_data_index), .in_data(in_data),
		.word_addr(pump_addr), .word_data(pump_word),
		.byte_group(group_index), .byte_index(byte_index), .byte_data(ram_byte)
	);

	readback_pump u_readback_pump (
		.clk(clk), .rst_n(rst_n), .pump_data_request(pump_data_request),
		.pump_data_request_ready(pump_data_request_ready),
		.word_addr(pump_addr), .word_data(pump_word),
		.out_data(out_data), .out_data_index(out_data_index)
	);

	ts_delay_line u_ts_delay_line (
		.clk(clk), .rst_n(rst_n), .mpeg_valid(mpeg_valid), .mpeg_sync(mpeg_sync),
		.mpeg_data(mpeg_data), .stage1_data(stage1_data), .stage2_data(stage2_data),
		.stage3_data(stage3_data), .stage2_sync(stage2_sync), .stage3_sync(stage3_sync)
	);

	packet_position_counter u_packet_position_counter (
		.clk(clk), .rst_n(rst_n), .emit(emit), .byte_index(byte_index),
		.group_index(group_index), .packet_last(packet_last), .restart(restart)
	);

	replace_fsm u_replace_fsm (
		.clk(clk), .rst_n(rst_n), .mpeg_valid(mpeg_valid),
		.stage2_data(stage2_data), .stage2_sync(stage2_sync), .pid_hit(pid_hit),
		.match_enable(match_enable), .pass_all(pass_all), .packet_last(packet_last),
		.emit(emit), .restart(restart), .forwarding(forwarding),
		.matched_count(matched_count)
	);

	header_rewriter u_header_rewriter (
		.clk(clk), .rst_n(rst_n), .emit(emit), .forwarding(forwarding),
		.stage3_data(stage3_data), .stage3_sync(stage3_sync), .ram_byte(ram_byte),
		.byte_index(byte_index), .group_index(group_index),
		.ts_out(ts_out), .ts_out_valid(ts_out_valid), .ts_out_sync(ts_out_sync)
	);

endmodule

// ==== tests/ts_ref_model.svh ====
`ifndef TS_REF_MODEL_SVH
`define TS_REF_MODEL_SVH

// one transport packet, byte 0 is the sync byte
typedef logic [`TS_PACKET_BYTES-1:0][7:0] ts_packet_t;

// host side image of the pid table and the replacement memory
logic [12:0] model_pid [`TS_PID_SLOTS];
logic        model_enable [`TS_PID_SLOTS];
logic [31:0] model_ram [`TS_RAM_WORDS];

// slot word as it reads back, padding cleared
function automatic logic [31:0] expected_slot(input int slot);
	return {15'b0, model_enable[slot], 3'b0, model_pid[slot]};
endfunction

function automatic bit table_hit(input logic [12:0] pid_value);
	bit hit;
	hit = 1'b0;
	for (int i = 0; i < `TS_PID_SLOTS; i++) begin
		if (model_enable[i] && (model_pid[i] == pid_value)) begin
			hit = 1'b1;
		end
	end
	return hit;
endfunction

function automatic logic [31:0] expected_word(input int index);
	return model_ram[index];
endfunction

function automatic logic [7:0] expected_byte(input ts_packet_t packet, input int index,
	input int group, input bit pass_all);
	int         addr;
	logic [7:0] value;
	addr = group * `TS_PACKET_BYTES + index;
	if (pass_all) begin
		value = packet[index];
	end else begin
		case (index)
			// pusi set only for the first group
			1: value = {packet[1][7], (group == 0), packet[1][5:0]};
			2: value = packet[2];
			3: value = {((group == 0) ? 2'b00 : 2'b01), 2'b11, packet[3][3:0]};
			// lane 0 is the low byte of each word
			default: value = model_ram[addr / 4][8 * (addr % 4) +: 8];
		endcase
	end
	return value;
endfunction

`endif

// ==== tests/tb_ts_replacer.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module tb_ts_replacer;
	import ts_replacer_pkg::*;

	`include "ts_ref_model.svh"

	localparam int WAIT_LIMIT = 2000;

	logic        clk;
	logic        rst_n;
	logic        update_pid_request;
	logic [31:0] pid_index;
	pid_cfg_u    pid;
	pid_cfg_u    out_pid;
	logic        update_data_request;
	logic [31:0] in_data_index;
	logic [31:0] in_data;
	logic        pump_data_request;
	logic        pump_data_request_ready;
	logic [31:0] out_data;
	logic [31:0] out_data_index;
	logic        match_enable;
	logic        pass_all;
	logic [31:0] matched_count;
	logic [7:0]  mpeg_data;
	logic        mpeg_valid;
	logic        mpeg_sync;
	logic [7:0]  ts_out;
	logic        ts_out_valid;
	logic        ts_out_sync;

	// {sync, byte} pairs
	logic [8:0]  expected_q [$];
	logic [8:0]  recent_in [$];
	logic [8:0]  out_item;
	int          model_group;
	int          model_matches;
	int unsigned seed_word;

	ts_replacer dut (
		.clk(clk), .rst_n(rst_n), .update_pid_request(update_pid_request),
		.pid_index(pid_index), .pid(pid), .out_pid(out_pid),
		.update_data_request(update_data_request), .in_data_index(in_data_index),
		.in_data(in_data), .pump_data_request(pump_data_request),
		.pump_data_request_ready(pump_data_request_ready), .out_data(out_data),
		.out_data_index(out_data_index), .match_enable(match_enable), .pass_all(pass_all),
		.matched_count(matched_count), .mpeg_data(mpeg_data), .mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync), .ts_out(ts_out), .ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic write_pid(input logic [31:0] index, input logic [31:0] word);
		update_pid_request = 1'b1;
		pid_index = index;
		pid.raw = word;
		if (index < `TS_PID_SLOTS) begin
			model_pid[index] = word[12:0];
			model_enable[index] = word[16];
		end
		@(negedge clk);
		update_pid_request = 1'b0;
	endtask

	task automatic check_slots();
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			pid_index = i;
			@(negedge clk);
			check_equal("out_pid", out_pid.raw, expected_slot(i));
		end
	endtask

	task automatic write_word(input int index, input logic [31:0] word);
		update_data_request = 1'b1;
		in_data_index = index;
		in_data = word;
		model_ram[index] = word;
		@(negedge clk);
		update_data_request = 1'b0;
	endtask

	task automatic run_pump();
		pump_data_request = 1'b1;
		@(negedge clk);
		pump_data_request = 1'b0;
		for (int i = 0; i < `TS_RAM_WORDS; i++) begin
			@(negedge clk);
			check_equal("out_data_index", out_data_index, i);
			check_equal("out_data", out_data, expected_word(i));
			check_equal("pump_data_request_ready", pump_data_request_ready, 0);
		end
		// ready returns one edge after the last word
		@(negedge clk);
		check_equal("pump_data_request_ready", pump_data_request_ready, 1);
	endtask

	// random idle cycles before each strobe
	task automatic send_byte(input logic [7:0] data, input logic sync);
		int         gap;
		logic [8:0] dropped;
		gap = $urandom % 3;
		repeat (gap) @(negedge clk);
		mpeg_valid = 1'b1;
		mpeg_data = data;
		mpeg_sync = sync;
		recent_in.push_back({sync, data});
		if (recent_in.size() > 2) begin
			dropped = recent_in.pop_front();
		end
		@(negedge clk);
		mpeg_valid = 1'b0;
	endtask

	function automatic ts_packet_t make_packet(input logic [12:0] pid_value);
		ts_packet_t pkt;
		for (int i = 0; i < `TS_PACKET_BYTES; i++) begin
			pkt[i] = 8'($urandom);
		end
		pkt[0] = `TS_SYNC_BYTE;
		pkt[1][4:0] = pid_value[12:8];
		pkt[2] = pid_value[7:0];
		return pkt;
	endfunction

	function automatic logic [12:0] free_pid();
		logic [12:0] value;
		value = 13'($urandom);
		while (table_hit(value)) begin
			value = value + 13'd1;
		end
		return value;
	endfunction

	task automatic send_packet(input ts_packet_t pkt);
		logic hit;
		hit = table_hit({pkt[1][4:0], pkt[2]});
		if (pass_all) begin
			for (int i = 0; i < `TS_PACKET_BYTES; i++) begin
				expected_q.push_back({(i == 0), expected_byte(pkt, i, 0, 1'b1)});
			end
		end else if (match_enable && hit) begin
			for (int i = 0; i < `TS_PACKET_BYTES; i++) begin
				expected_q.push_back({(i == 0), expected_byte(pkt, i, model_group, 1'b0)});
			end
			model_group = (model_group + 1) % `TS_DATA_GROUPS;
			model_matches++;
		end
		for (int i = 0; i < `TS_PACKET_BYTES; i++) begin
			send_byte(pkt[i], (i == 0));
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (expected_q.size() != 0) begin
			abort_run("timeout waiting for the expected output bytes");
		end
	endtask

	// every output pulse must match the oldest expected byte
	always @(negedge clk) begin
		if (ts_out_valid === 1'b1) begin
			assert (expected_q.size() != 0) else begin
				abort_run("ts_out_valid pulsed while no output byte was expected");
			end
			out_item = expected_q.pop_front();
			check_equal("ts_out", ts_out, out_item[7:0]);
			check_equal("ts_out_sync", ts_out_sync, out_item[8]);
		end
	end

	initial begin
		seed_word = $urandom(32'h9df7);
		clk = 1'b0;
		rst_n = 1'b0;
		update_pid_request = 1'b0;
		pid_index = '0;
		pid.raw = '0;
		update_data_request = 1'b0;
		in_data_index = '0;
		in_data = '0;
		pump_data_request = 1'b0;
		match_enable = 1'b0;
		pass_all = 1'b0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			model_pid[i] = '0;
			model_enable[i] = 1'b0;
		end
		model_group = 0;
		model_matches = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_equal("ts_out_sync", ts_out_sync, 0);
		check_equal("pump_data_request_ready", pump_data_request_ready, 0);
		check_equal("matched_count", matched_count, 0);

		// pid table followed by a write past the last slot
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			write_pid(i, $urandom);
		end
		check_slots();
		write_pid(`TS_PID_SLOTS + ($urandom % 64), $urandom);
		check_slots();
		write_pid(0, 32'h0001_0000 | ($urandom & 32'h1fff));
		write_pid(1, 32'h0001_0000 | ($urandom & 32'h1fff));
		check_slots();

		for (int i = 0; i < `TS_RAM_WORDS; i++) begin
			write_word(i, $urandom);
		end
		run_pump();
		// a second sweep starts with ready high
		run_pump();

		// mixed stream whose trailing packet never matches and so flushes the delay line
		match_enable = 1'b1;
		for (int n = 0; n < 10; n++) begin
			if (n < 2 || ($urandom % 3) != 0) begin
				send_packet(make_packet(model_pid[$urandom % 2]));
			end else begin
				send_packet(make_packet(free_pid()));
			end
		end
		send_packet(make_packet(free_pid()));
		wait_drained();
		check_equal("matched_count", matched_count, model_matches);

		match_enable = 1'b0;
		for (int n = 0; n < 3; n++) begin
			send_packet(make_packet(model_pid[0]));
		end
		send_packet(make_packet(free_pid()));
		wait_drained();
		check_equal("matched_count", matched_count, model_matches);

		// the two newest bytes still in the delay line come out first
		expected_q.push_back(recent_in[0]);
		expected_q.push_back(recent_in[1]);
		pass_all = 1'b1;
		for (int n = 0; n < 3; n++) begin
			send_packet(make_packet(13'($urandom)));
		end
		repeat (3) send_byte(8'($urandom), 1'b0);
		wait_drained();
		check_equal("matched_count", matched_count, model_matches);

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== ts_replacer.f ====
+incdir+common
+incdir+tests
common/ts_replacer_pkg.sv
design/pid_filter_table.sv
design/replace_data_ram.sv
design/readback_pump.sv
ts_rewrite/ts_delay_line.sv
ts_rewrite/packet_position_counter.sv
ts_rewrite/replace_fsm.sv
ts_rewrite/header_rewriter.sv
design/ts_replacer.sv
tests/tb_ts_replacer.sv

// ==== ts_rewrite/header_rewriter.sv ====
`timescale 1ns/1ps

module header_rewriter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          emit,
	input  logic                          forwarding,
	input  logic [7:0]                    stage3_data,
	input  logic                          stage3_sync,
	input  logic [7:0]                    ram_byte,
	input  ts_replacer_pkg::byte_index_t  byte_index,
	input  ts_replacer_pkg::group_index_t group_index,
	output logic [7:0]                    ts_out,
	output logic                          ts_out_valid,
	output logic                          ts_out_sync
);
	import ts_replacer_pkg::*;

	logic       first_group;
	logic [7:0] next_byte;

	assign first_group = (group_index == '0);

	always_comb begin
		if (forwarding) begin
			next_byte = stage3_data;
		end else begin
			case (byte_index)
				// pusi follows the group, error and priority bits and pid high kept
				byte_index_t'(1): next_byte = {stage3_data[7], first_group, stage3_data[5:0]};
				// pid low byte
				byte_index_t'(2): next_byte = stage3_data;
				// scrambling and adaptation field control, continuity counter kept
				byte_index_t'(3): next_byte = {(first_group ? 2'b00 : 2'b01), 2'b11,
					stage3_data[3:0]};
				default: next_byte = ram_byte;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ts_out <= '0;
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= emit;
			if (emit) begin
				ts_out <= next_byte;
				ts_out_sync <= stage3_sync;
			end
		end
	end

endmodule

// ==== ts_rewrite/packet_position_counter.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module packet_position_counter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          emit,
	output ts_replacer_pkg::byte_index_t  byte_index,
	output ts_replacer_pkg::group_index_t group_index,
	output logic                          packet_last,
	input  logic                          restart
);
	import ts_replacer_pkg::*;

	logic at_end;

	assign at_end = (byte_index == byte_index_t'(`TS_PACKET_BYTES - 1));
	assign packet_last = emit && at_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_index <= '0;
			group_index <= '0;
		end else begin
			// a new sync decision may land on the last byte of the previous packet
			if (restart || packet_last) begin
				byte_index <= '0;
			end else if (emit) begin
				byte_index <= byte_index + 1'b1;
			end

			if (packet_last) begin
				if (group_index == group_index_t'(`TS_DATA_GROUPS - 1)) begin
					group_index <= '0;
				end else begin
					group_index <= group_index + 1'b1;
				end
			end
		end
	end

endmodule

// ==== ts_rewrite/replace_fsm.sv ====
`timescale 1ns/1ps
`include "ts_replacer_macros.svh"

module replace_fsm (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mpeg_valid,
	input  logic [7:0]                stage2_data,
	input  logic                      stage2_sync,
	input  logic                      pid_hit,
	input  logic                      match_enable,
	input  logic                      pass_all,
	input  logic                      packet_last,
	output logic                      emit,
	output logic                      restart,
	output logic                      forwarding,
	output logic [`TS_DATA_WIDTH-1:0] matched_count
);

	localparam logic [1:0] ST_DROP    = 2'd0;
	localparam logic [1:0] ST_REPLACE = 2'd1;
	localparam logic [1:0] ST_FORWARD = 2'd2;

	logic [1:0] state;
	logic       sync_seen;
	logic       decide;
	logic       match_pulse;

	// packet start sits in stage 2 while the pid bytes are in stage 1 and the input
	assign sync_seen = stage2_sync && (stage2_data == `TS_SYNC_BYTE);
	assign decide = mpeg_valid && !pass_all && sync_seen;
	assign match_pulse = decide && pid_hit && match_enable;

	// pass-all keeps the position counter parked at byte 0
	assign restart = decide || (mpeg_valid && pass_all);

	assign forwarding = (state == ST_FORWARD);
	assign emit = mpeg_valid && ((state == ST_REPLACE) || forwarding);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_DROP;
			matched_count <= '0;
		end else begin
			if (match_pulse) begin
				matched_count <= matched_count + 1'b1;
			end

			if (mpeg_valid) begin
				if (pass_all) begin
					state <= ST_FORWARD;
				end else if (decide) begin
					state <= (pid_hit && match_enable) ? ST_REPLACE : ST_DROP;
				end else if (packet_last || forwarding) begin
					state <= ST_DROP;
				end
			end
		end
	end

endmodule

// ==== ts_rewrite/ts_delay_line.sv ====
`timescale 1ns/1ps

module ts_delay_line (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mpeg_valid,
	input  logic       mpeg_sync,
	input  logic [7:0] mpeg_data,
	output logic [7:0] stage1_data,
	output logic [7:0] stage2_data,
	output logic [7:0] stage3_data,
	output logic       stage2_sync,
	output logic       stage3_sync
);

	logic stage1_sync;

	// sync flags are control and get cleared
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage1_sync <= 1'b0;
			stage2_sync <= 1'b0;
			stage3_sync <= 1'b0;
		end else if (mpeg_valid) begin
			stage1_sync <= mpeg_sync;
			stage2_sync <= stage1_sync;
			stage3_sync <= stage2_sync;
		end
	end

	// byte pipeline, moves only on the stream strobe
	always_ff @(posedge clk) begin
		if (mpeg_valid) begin
			stage1_data <= mpeg_data;
			stage2_data <= stage1_data;
			stage3_data <= stage2_data;
		end
	end

endmodule
